//--- readout_consts.svh
// Width, channel count, request and DAQ tag constants for the readout path
`ifndef READOUT_CONSTS_SVH
`define READOUT_CONSTS_SVH

// Channel word and DAQ beat widths
`define DATA_W 32
`define DAQ_W 64
`define DEST_W 4
`define LEN_W 20

// Channels read per trigger
`define NUM_CHAN 4

// Second word of every channel readout request
`define CAL_CYCLES 8

// DAQ framing tags
`define CHAN_TAG 8'h01
`define AMC_TAG 8'h00
`define HDR2_WORD 64'h1

`endif

//--- readout_pkg.sv
// Readout sequencer state type and DAQ word-kind type
package readout_pkg;

  typedef enum logic [3:0] {
    IDLE,
    TAKE_TRIGGER,
    REQUEST,
    READ_RSN,
    READ_RC,
    READ_TRIG,
    READ_SIZE,
    READ_CHAN,
    READ_PTC,
    SEND_AMC_HDR1,
    SEND_AMC_HDR2,
    SEND_CHAN_HDR,
    READ_DATA,
    READ_CHECKSUM,
    SEND_AMC_TRL
  } readout_state_t;

  typedef enum logic [2:0] {
    AMC_HDR1,
    AMC_HDR2,
    CHAN_HDR,
    DATA,
    AMC_TRL
  } daq_word_t;

endpackage

//--- chan_request.sv
// Channel readout request sender with request sequence number
`include "readout_consts.svh"

module chan_request (
  input  logic               clk,
  input  logic               rst,
  input  logic               req_start,
  input  logic [`DEST_W-1:0] req_dest,
  output logic               req_done,
  output logic               chan_tx_fifo_valid,
  output logic [`DATA_W-1:0] chan_tx_fifo_data,
  output logic [`DEST_W-1:0] chan_tx_fifo_dest,
  output logic               chan_tx_fifo_last,
  input  logic               chan_tx_fifo_ready
);

  logic [`DATA_W-1:0] csn;
  logic [`DEST_W-1:0] dest_q;
  logic               tx_fire;

  assign tx_fire = chan_tx_fifo_valid && chan_tx_fifo_ready;

  // Word 1 is the CSN, word 2 the calibration cycle count
  assign chan_tx_fifo_data = chan_tx_fifo_last ? `DATA_W'(`CAL_CYCLES) : csn;
  assign chan_tx_fifo_dest = dest_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      chan_tx_fifo_valid <= 1'b0;
      chan_tx_fifo_last  <= 1'b0;
      req_done           <= 1'b0;
      csn                <= '0;
    end else begin
      req_done <= 1'b0;
      if (req_start) begin
        chan_tx_fifo_valid <= 1'b1;
        chan_tx_fifo_last  <= 1'b0;
      end else if (tx_fire) begin
        if (chan_tx_fifo_last) begin
          chan_tx_fifo_valid <= 1'b0;
          chan_tx_fifo_last  <= 1'b0;
          req_done           <= 1'b1;
          csn                <= csn + 1'b1; // Wraps at 32 bits
        end else begin
          chan_tx_fifo_last <= 1'b1; // Move on to second word
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_start) begin
      dest_q <= req_dest;
    end
  end

endmodule

//--- word_packer.sv
// Packs pairs of 32-bit channel words into 64-bit DAQ beats
`include "readout_consts.svh"

module word_packer (
  input  logic               clk,
  input  logic               rst,
  input  logic               data_take,
  input  logic [`DATA_W-1:0] rx_data,
  input  logic [`DATA_W-1:0] buf_size,
  output logic               word_wanted,
  output logic               pair_valid,
  output logic [`DAQ_W-1:0]  pair_data,
  output logic               last_pair,
  input  logic               pair_ack
);

  logic               upper_held;
  logic [`DATA_W-1:0] word_cnt;

  // No new words while a finished pair waits for the framer
  assign word_wanted = !pair_valid;
  assign last_pair   = pair_valid && (word_cnt == buf_size);

  always_ff @(posedge clk) begin
    if (rst) begin
      upper_held <= 1'b0;
      pair_valid <= 1'b0;
      word_cnt   <= '0;
    end else begin
      if (data_take) begin
        word_cnt   <= word_cnt + 1'b1;
        upper_held <= !upper_held;
        if (upper_held) begin
          pair_valid <= 1'b1; // Second word completes the beat
        end
      end
      if (pair_ack) begin
        pair_valid <= 1'b0;
        if (last_pair) begin
          word_cnt <= '0; // Ready for the next channel
        end
      end
    end
  end

  // First word to the upper half, second to the lower half
  always_ff @(posedge clk) begin
    if (data_take) begin
      if (upper_held) begin
        pair_data[`DATA_W-1:0] <= rx_data;
      end else begin
        pair_data[`DAQ_W-1:`DATA_W] <= rx_data;
      end
    end
  end

endmodule

//--- daq_framer.sv
// DAQ word builder and DAQ output register
`include "readout_consts.svh"

module daq_framer import readout_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               word_load,
  input  daq_word_t          word_kind,
  input  logic [`DATA_W-1:0] trig_num,
  input  logic [7:0]         chan_num,
  input  logic [`DATA_W-1:0] buf_size,
  input  logic [`DAQ_W-1:0]  pair_data,
  output logic               word_free,
  output logic               daq_valid,
  output logic [`DAQ_W-1:0]  daq_data,
  output logic               daq_header,
  output logic               daq_trailer,
  input  logic               daq_ready
);

  logic [`LEN_W-1:0] len_calc;
  logic [`LEN_W-1:0] len_q;
  logic [`DAQ_W-1:0] word_next;

  // Event length in beats: per channel one header plus buf_size/2 data beats
  assign len_calc = `LEN_W'(`NUM_CHAN) * (`LEN_W'(1) + `LEN_W'(buf_size[`DATA_W-1:1]))
                    + `LEN_W'(3);

  assign word_free = !daq_valid;

  always_comb begin
    case (word_kind)
      AMC_HDR1: word_next = {`AMC_TAG, trig_num[23:0], 12'h000, len_calc};
      AMC_HDR2: word_next = `HDR2_WORD;
      CHAN_HDR: word_next = {`CHAN_TAG, chan_num, trig_num[23:0], buf_size[23:0]};
      AMC_TRL:  word_next = {32'h0, trig_num[7:0], 4'h0, len_q};
      default:  word_next = pair_data;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      daq_valid   <= 1'b0;
      daq_header  <= 1'b0;
      daq_trailer <= 1'b0;
    end else if (word_load) begin
      daq_valid   <= 1'b1;
      daq_header  <= (word_kind == AMC_HDR1);
      daq_trailer <= (word_kind == AMC_TRL);
    end else if (daq_valid && daq_ready) begin
      daq_valid   <= 1'b0;
      daq_header  <= 1'b0;
      daq_trailer <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (word_load) begin
      daq_data <= word_next;
    end
    if (word_load && word_kind == AMC_HDR1) begin
      len_q <= len_calc; // Trailer reuses the channel 0 length
    end
  end

endmodule

//--- readout_sequencer.sv
// Trigger-to-event FSM: reply header capture, DAQ word sequencing and channel walk
`include "readout_consts.svh"

module readout_sequencer import readout_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               tm_fifo_valid,
  output logic               tm_fifo_ready,
  output logic               busy,
  input  logic               chan_rx_fifo_valid,
  input  logic [`DATA_W-1:0] chan_rx_fifo_data,
  input  logic               chan_rx_fifo_last,
  output logic               chan_rx_fifo_ready,
  output logic               req_start,
  output logic [`DEST_W-1:0] req_dest,
  input  logic               req_done,
  output logic               data_take,
  output logic [`DATA_W-1:0] buf_size,
  input  logic               word_wanted,
  input  logic               pair_valid,
  input  logic               last_pair,
  output logic               pair_ack,
  output logic               word_load,
  output daq_word_t          word_kind,
  output logic [`DATA_W-1:0] trig_num,
  output logic [7:0]         chan_num,
  input  logic               word_free
);

  readout_state_t     state;
  readout_state_t     state_next;
  logic [`DEST_W-1:0] chan_idx;
  logic               rx_take;
  logic               last_chan;
  logic               trl_loaded;
  logic               hdr_state;

  assign rx_take   = chan_rx_fifo_valid && chan_rx_fifo_ready;
  assign last_chan = (chan_idx == `DEST_W'(`NUM_CHAN - 1));
  assign hdr_state = (state == SEND_AMC_HDR1) || (state == SEND_AMC_HDR2) ||
                     (state == SEND_CHAN_HDR);

  assign busy          = (state != IDLE);
  assign tm_fifo_ready = (state == TAKE_TRIGGER); // Pops one notice
  assign req_dest      = chan_idx;
  assign data_take     = (state == READ_DATA) && rx_take;
  assign pair_ack      = (state == READ_DATA) && pair_valid && word_free;
  assign word_load     = pair_ack || (hdr_state && word_free) ||
                         ((state == SEND_AMC_TRL) && word_free && !trl_loaded);

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (tm_fifo_valid) state_next = TAKE_TRIGGER;
      TAKE_TRIGGER:  state_next = REQUEST;
      REQUEST:       if (req_done) state_next = READ_RSN;
      READ_RSN:      if (rx_take) state_next = READ_RC;
      READ_RC:       if (rx_take) state_next = READ_TRIG;
      READ_TRIG:     if (rx_take) state_next = READ_SIZE;
      READ_SIZE:     if (rx_take) state_next = READ_CHAN;
      READ_CHAN:     if (rx_take) state_next = READ_PTC;
      READ_PTC: begin
        if (rx_take) begin
          state_next = (chan_idx == '0) ? SEND_AMC_HDR1 : SEND_CHAN_HDR;
        end
      end
      SEND_AMC_HDR1: if (word_free) state_next = SEND_AMC_HDR2;
      SEND_AMC_HDR2: if (word_free) state_next = SEND_CHAN_HDR;
      SEND_CHAN_HDR: if (word_free) state_next = READ_DATA;
      READ_DATA:     if (pair_ack && last_pair) state_next = READ_CHECKSUM;
      READ_CHECKSUM: begin
        if (rx_take && chan_rx_fifo_last) begin
          state_next = last_chan ? SEND_AMC_TRL : REQUEST;
        end
      end
      SEND_AMC_TRL:  if (trl_loaded && word_free) state_next = IDLE; // Trailer has left
      default:       state_next = IDLE;
    endcase
  end

  always_comb begin
    case (state)
      READ_RSN, READ_RC, READ_TRIG, READ_SIZE,
      READ_CHAN, READ_PTC, READ_CHECKSUM: chan_rx_fifo_ready = 1'b1;
      READ_DATA:                          chan_rx_fifo_ready = word_wanted;
      default:                            chan_rx_fifo_ready = 1'b0;
    endcase
  end

  always_comb begin
    case (state)
      SEND_AMC_HDR1: word_kind = AMC_HDR1;
      SEND_AMC_HDR2: word_kind = AMC_HDR2;
      SEND_CHAN_HDR: word_kind = CHAN_HDR;
      SEND_AMC_TRL:  word_kind = AMC_TRL;
      default:       word_kind = DATA;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= IDLE;
      chan_idx   <= '0;
      req_start  <= 1'b0;
      trl_loaded <= 1'b0;
    end else begin
      state      <= state_next;
      req_start  <= (state_next == REQUEST) && (state != REQUEST); // One pulse per channel
      trl_loaded <= (state == SEND_AMC_TRL) && (state_next == SEND_AMC_TRL) &&
                    (trl_loaded || word_free);
      if (state == TAKE_TRIGGER) begin
        chan_idx <= '0;
      end else if ((state == READ_CHECKSUM) && (state_next == REQUEST)) begin
        chan_idx <= chan_idx + 1'b1;
      end
    end
  end

  // RSN, RC and post-trigger count are read and dropped
  always_ff @(posedge clk) begin
    if ((state == READ_TRIG) && rx_take) begin
      trig_num <= chan_rx_fifo_data;
    end
    if ((state == READ_SIZE) && rx_take) begin
      buf_size <= chan_rx_fifo_data;
    end
    if ((state == READ_CHAN) && rx_take) begin
      chan_num <= chan_rx_fifo_data[7:0];
    end
  end

endmodule

//--- readout_top.sv
// Readout path top level: sequencer, request sender, word packer and DAQ framer
`include "readout_consts.svh"

module readout_top import readout_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               tm_fifo_valid,
  output logic               tm_fifo_ready,
  output logic               chan_tx_fifo_valid,
  output logic [`DATA_W-1:0] chan_tx_fifo_data,
  output logic [`DEST_W-1:0] chan_tx_fifo_dest,
  output logic               chan_tx_fifo_last,
  input  logic               chan_tx_fifo_ready,
  input  logic               chan_rx_fifo_valid,
  input  logic [`DATA_W-1:0] chan_rx_fifo_data,
  input  logic               chan_rx_fifo_last,
  output logic               chan_rx_fifo_ready,
  output logic               daq_valid,
  output logic [`DAQ_W-1:0]  daq_data,
  output logic               daq_header,
  output logic               daq_trailer,
  input  logic               daq_ready,
  output logic               busy
);

  logic               req_start;
  logic [`DEST_W-1:0] req_dest;
  logic               req_done;
  logic               data_take;
  logic [`DATA_W-1:0] buf_size;
  logic               word_wanted;
  logic               pair_valid;
  logic [`DAQ_W-1:0]  pair_data;
  logic               last_pair;
  logic               pair_ack;
  logic               word_load;
  daq_word_t          word_kind;
  logic [`DATA_W-1:0] trig_num;
  logic [7:0]         chan_num;
  logic               word_free;

  readout_sequencer u_seq (
    .clk, .rst, .tm_fifo_valid, .tm_fifo_ready, .busy,
    .chan_rx_fifo_valid, .chan_rx_fifo_data, .chan_rx_fifo_last, .chan_rx_fifo_ready,
    .req_start, .req_dest, .req_done,
    .data_take, .buf_size, .word_wanted, .pair_valid, .last_pair, .pair_ack,
    .word_load, .word_kind, .trig_num, .chan_num, .word_free
  );

  chan_request u_req (
    .clk, .rst, .req_start, .req_dest, .req_done,
    .chan_tx_fifo_valid, .chan_tx_fifo_data, .chan_tx_fifo_dest,
    .chan_tx_fifo_last, .chan_tx_fifo_ready
  );

  word_packer u_pack (
    .clk, .rst, .data_take,
    .rx_data (chan_rx_fifo_data), // Same bus the sequencer reads
    .buf_size, .word_wanted, .pair_valid, .pair_data, .last_pair, .pair_ack
  );

  daq_framer u_frame (
    .clk, .rst, .word_load, .word_kind, .trig_num, .chan_num, .buf_size, .pair_data,
    .word_free, .daq_valid, .daq_data, .daq_header, .daq_trailer, .daq_ready
  );

endmodule

//--- readout_sva.sv
// Bound protocol assertions on the readout top-level ports
`include "readout_consts.svh"

module readout_sva (
  input logic               clk,
  input logic               rst,
  input logic               chan_tx_fifo_valid,
  input logic [`DATA_W-1:0] chan_tx_fifo_data,
  input logic [`DEST_W-1:0] chan_tx_fifo_dest,
  input logic               chan_tx_fifo_last,
  input logic               chan_tx_fifo_ready,
  input logic               daq_valid,
  input logic [`DAQ_W-1:0]  daq_data,
  input logic               daq_header,
  input logic               daq_trailer,
  input logic               daq_ready
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_count;

  initial fail_count = 0;

  tx_hold: assert property (@(posedge clk) disable iff (rst)
    chan_tx_fifo_valid && !chan_tx_fifo_ready |=> chan_tx_fifo_valid &&
      $stable(chan_tx_fifo_data) && $stable(chan_tx_fifo_dest) && $stable(chan_tx_fifo_last))
    else begin
      fail_count++;
      $error("Channel transmit word changed while stalled");
    end

  daq_hold: assert property (@(posedge clk) disable iff (rst)
    daq_valid && !daq_ready |=> daq_valid &&
      $stable(daq_data) && $stable(daq_header) && $stable(daq_trailer))
    else begin
      fail_count++;
      $error("DAQ beat changed while stalled");
    end

  flag_valid: assert property (@(posedge clk) disable iff (rst)
    (daq_header || daq_trailer) |-> daq_valid)
    else begin
      fail_count++;
      $error("DAQ header or trailer flag without daq_valid");
    end

endmodule

bind readout_top readout_sva u_sva (.*);

//--- readout_tb.sv
// Readout testbench: clock, reset, channel responder, DAQ reference model, checks, watchdog
`include "readout_consts.svh"

module readout_tb import readout_pkg::*; ;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_EVENTS = 20;
  localparam int MAX_WORDS  = 16;

  logic clk, rst, tm_fifo_valid, tm_fifo_ready, busy;
  logic chan_tx_fifo_valid, chan_tx_fifo_last, chan_tx_fifo_ready;
  logic [`DATA_W-1:0] chan_tx_fifo_data;
  logic [`DEST_W-1:0] chan_tx_fifo_dest;
  logic chan_rx_fifo_valid, chan_rx_fifo_last, chan_rx_fifo_ready;
  logic [`DATA_W-1:0] chan_rx_fifo_data;
  logic daq_valid, daq_header, daq_trailer, daq_ready;
  logic [`DAQ_W-1:0] daq_data;

  logic [`DATA_W-1:0] chan_words [`NUM_CHAN][MAX_WORDS];
  logic [`DATA_W-1:0] ev_size, ev_index;
  logic [65:0]        exp_q [$]; // {header, trailer, data}
  daq_word_t          kind_q [$];
  int                 req_q [$];
  int                 req_count, events_done, err_count;

  readout_top dut (.*);

  task automatic report_mismatch(input string test, input logic [63:0] expected,
                                 input logic [63:0] actual);
    err_count++;
    $display("ERR %s expected %h actual %h", test, expected, actual);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic report_error(input string what);
    err_count++;
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic push_beat(input daq_word_t kind, input logic hdr, input logic trl,
                           input logic [`DAQ_W-1:0] data);
    exp_q.push_back({hdr, trl, data});
    kind_q.push_back(kind);
  endtask

  // Reference model of one event and its channel data words
  task automatic build_event(input logic [`DATA_W-1:0] e);
    logic [`LEN_W-1:0] len;
    ev_size  = 2 * $urandom_range(1, MAX_WORDS / 2);
    ev_index = e;
    len      = `NUM_CHAN * (1 + ev_size / 2) + 3;
    push_beat(AMC_HDR1, 1'b1, 1'b0, {`AMC_TAG, e[23:0], 12'h000, len});
    push_beat(AMC_HDR2, 1'b0, 1'b0, `HDR2_WORD);
    for (int c = 0; c < `NUM_CHAN; c++) begin
      push_beat(CHAN_HDR, 1'b0, 1'b0, {`CHAN_TAG, 8'(c), e[23:0], ev_size[23:0]});
      for (int i = 0; i < ev_size; i++) chan_words[c][i] = $urandom;
      for (int i = 0; i < ev_size; i += 2) begin
        push_beat(DATA, 1'b0, 1'b0, {chan_words[c][i], chan_words[c][i+1]});
      end
    end
    push_beat(AMC_TRL, 1'b0, 1'b1, {32'h0, e[7:0], 4'h0, len});
  endtask

  // Called 1 ns after an edge and returns 1 ns after the transfer edge
  task automatic send_rx_word(input logic [`DATA_W-1:0] word, input logic last);
    int gap;
    gap = $urandom_range(0, 2);
    repeat (gap) begin
      @(posedge clk);
      #1;
    end
    chan_rx_fifo_valid = 1'b1;
    chan_rx_fifo_data  = word;
    chan_rx_fifo_last  = last;
    @(posedge clk);
    while (!chan_rx_fifo_ready) @(posedge clk);
    #1;
    chan_rx_fifo_valid = 1'b0;
    chan_rx_fifo_last  = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin : back_pressure
    forever begin
      @(posedge clk);
      #1;
      daq_ready          = ($urandom % 4) != 0;
      chan_tx_fifo_ready = $urandom % 2;
    end
  end

  initial begin : responder
    int dest;
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      if (req_q.size() != 0) begin
        dest = req_q.pop_front();
        send_rx_word($urandom, 1'b0); // RSN
        send_rx_word($urandom, 1'b0); // RC
        send_rx_word(ev_index, 1'b0);
        send_rx_word(ev_size, 1'b0);
        send_rx_word(dest, 1'b0);
        send_rx_word($urandom, 1'b0); // Post-trigger count
        for (int i = 0; i < ev_size; i++) send_rx_word(chan_words[dest][i], 1'b0);
        send_rx_word($urandom, 1'b1); // Checksum
      end
    end
  end

  initial begin : tx_monitor
    logic second;
    second = 1'b0;
    forever begin
      @(posedge clk);
      if (!rst && chan_tx_fifo_valid && chan_tx_fifo_ready) begin
        assert (chan_tx_fifo_dest == req_count % `NUM_CHAN)
          else report_mismatch("request dest", req_count % `NUM_CHAN, chan_tx_fifo_dest);
        assert (chan_tx_fifo_last == second)
          else report_mismatch("request last", second, chan_tx_fifo_last);
        if (!second) begin
          assert (chan_tx_fifo_data == req_count)
            else report_mismatch("request CSN", req_count, chan_tx_fifo_data);
        end else begin
          assert (chan_tx_fifo_data == `CAL_CYCLES)
            else report_mismatch("request cal cycles", `CAL_CYCLES, chan_tx_fifo_data);
          req_q.push_back(int'(chan_tx_fifo_dest));
          req_count++;
        end
        second = !second;
      end
    end
  end

  initial begin : daq_monitor
    logic [65:0] beat;
    daq_word_t   kind;
    forever begin
      @(posedge clk);
      assert (dut.u_sva.fail_count == 0) else report_error("A bound protocol assertion failed");
      if (!rst && daq_valid && daq_ready) begin
        assert (exp_q.size() != 0) else report_error("DAQ beat arrived with none expected");
        beat = exp_q.pop_front();
        kind = kind_q.pop_front();
        assert (daq_data == beat[63:0])
          else report_mismatch({"DAQ ", kind.name(), " data"}, beat[63:0], daq_data);
        assert ({daq_header, daq_trailer} == beat[65:64])
          else report_mismatch({"DAQ ", kind.name(), " flags"}, beat[65:64],
                               {daq_header, daq_trailer});
        if (daq_trailer) events_done++;
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_EVENTS * 2000) @(posedge clk);
    $display("Timeout: run did not finish within %0d cycles", NUM_EVENTS * 2000);
    $display("=== FAIL ===");
    $fatal(1, "Watchdog expired");
  end

  initial begin : main
    int n;
    void'($urandom(32'hcc07_a2e0));
    rst = 1'b1;
    tm_fifo_valid      = 1'b0;
    chan_tx_fifo_ready = 1'b0;
    chan_rx_fifo_valid = 1'b0;
    chan_rx_fifo_data  = '0;
    chan_rx_fifo_last  = 1'b0;
    daq_ready          = 1'b0;
    req_count   = 0;
    events_done = 0;
    err_count   = 0;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    repeat (8) begin
      @(posedge clk);
      assert (!busy && !daq_valid && !chan_tx_fifo_valid && !chan_rx_fifo_ready &&
              !tm_fifo_ready)
        else report_error("Outputs active after reset before the first trigger");
    end
    #1;
    for (int e = 0; e < NUM_EVENTS; e++) begin
      build_event(e);
      tm_fifo_valid = 1'b1;
      @(posedge clk);
      while (!tm_fifo_ready) @(posedge clk);
      #1 tm_fifo_valid = 1'b0;
      while (events_done < e + 1) begin
        @(posedge clk);
        #1;
      end
      n = 0;
      while (busy && n < 4) begin // IDLE follows the trailer transfer by one cycle
        @(posedge clk);
        #1;
        n++;
      end
      assert (!busy) else report_error("busy stayed high after the trailer transfer");
      assert (req_count == (e + 1) * `NUM_CHAN)
        else report_mismatch("requests per event", (e + 1) * `NUM_CHAN, req_count);
    end
    assert (exp_q.size() == 0) else report_error("DAQ beats missing at the end of the run");
    if (err_count == 0 && dut.u_sva.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- list.f
+incdir+.
readout_pkg.sv
chan_request.sv
word_packer.sv
daq_framer.sv
readout_sequencer.sv
readout_top.sv
readout_sva.sv
readout_tb.sv
